// ==== all.f ====
src/hex_video_pkg.sv
src/beam_timing.sv
src/hex_display_regs.sv
src/hex_glyph_renderer.sv
src/tmds_encoder.sv
src/hex_dvi_top.sv
verif/hex_dvi_properties.sv
verif/hex_dvi_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the hex dvi testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module hex_dvi_tb -f all.f -o hex_dvi_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/hex_dvi_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation ended with status $status"
  exit "$status"
fi

exit 0

// ==== verif/hex_dvi_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module hex_dvi_tb;

  localparam int          CLK_PERIOD_NS  = 40;
  localparam int          DRIVE_NS       = 2;     // input skew after the rising edge
  localparam int          RESET_CYCLES   = 8;
  localparam int          CELL_SCALE     = 2;     // top level default
  localparam logic [15:0] FG_COLOR       = 16'hFFFF;
  localparam int          CELL_PX        = 8 * CELL_SCALE;
  localparam int          TEXT_LINES     = 2 * CELL_PX;
  localparam int          DIGITS         = 32;
  localparam int          H_VISIBLE      = 640;
  localparam int          V_VISIBLE      = 480;
  localparam int          LINE_PX        = 800;
  localparam int          FRAME_LINES    = 525;
  localparam int          FRAME_PX       = LINE_PX * FRAME_LINES;
  localparam int          HS_FIRST       = 656;
  localparam int          HS_LAST        = 751;
  localparam int          VS_FIRST       = 490;
  localparam int          VS_LAST        = 491;
  localparam int          PIPE_LAG       = 3;     // beam position to symbol
  // third frame's text rows plus two lines
  localparam int          END_POS        = 2 * FRAME_PX + (TEXT_LINES + 2) * LINE_PX;
  // END_POS is about 867k cycles, so two frames plus the text rows and margin
  localparam int          TIMEOUT_CYCLES = 900000;

  // dvi control symbols by {c1, c0}
  localparam logic [9:0] CTRL_SYM [4] = '{
    10'b1101010100, 10'b0010101011, 10'b0101010100, 10'b1010101011
  };

  logic                    clk_25mhz;
  logic                    arst_n;
  hex_video_pkg::apb_req_t apb_req;
  hex_video_pkg::apb_rsp_t apb_rsp;
  hex_video_pkg::tmds_t    tmds;

  logic [31:0] lcg_state;
  logic [31:0] wr_words [8];
  logic [31:0] new_word0;
  int          edge_cnt;     // rising edges since reset release

  hex_dvi_top UUT (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .tmds      (tmds)
  );

  always #(CLK_PERIOD_NS / 2) clk_25mhz = ~clk_25mhz;

  always @(posedge clk_25mhz or negedge arst_n)
  begin
    if (!arst_n)
    begin
      edge_cnt <= 0;
    end
    else
    begin
      edge_cnt <= edge_cnt + 1;
    end
  end

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // undo the dc inversion, then the xor or xnor chain
  function automatic logic [7:0] decode_tmds(input logic [9:0] sym);
    logic [7:0] q;
    logic [7:0] d;
    q    = sym[9] ? ~sym[7:0] : sym[7:0];
    d[0] = q[0];
    for (int i = 1; i < 8; i++)
    begin
      d[i] = sym[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
    end
    return d;
  endfunction

  // buffer contents the screen should show in a given frame
  function automatic logic [255:0] shown_buffer(input int frame);
    logic [255:0] v;
    v = '0;
    if (frame >= 1)
    begin
      for (int i = 0; i < 8; i++)
      begin
        v[32*i +: 32] = wr_words[i];
      end
    end
    if (frame >= 2)
    begin
      v[31:0] = new_word0;   // overwritten in frame 1 blanking
    end
    return v;
  endfunction

  function automatic logic [15:0] expected_pixel(input int x, input int y,
                                                 input logic [255:0] buffer);
    int         col;
    int         text_row;
    int         nib_pos;
    int         font_row;
    int         font_col;
    logic [3:0] nibble;
    logic [7:0] glyph_row;
    col      = x / CELL_PX;
    text_row = y / CELL_PX;
    if (text_row >= 2 || col >= DIGITS)
    begin
      return 16'h0000;
    end
    nib_pos   = text_row * DIGITS + (DIGITS - 1 - col);   // msd on the left
    nibble    = buffer[nib_pos*4 +: 4];
    font_row  = (y / CELL_SCALE) % 8;
    font_col  = (x / CELL_SCALE) % 8;
    glyph_row = hex_video_pkg::HEX_FONT[nibble][font_row];
    return glyph_row[7 - font_col] ? FG_COLOR : 16'h0000;
  endfunction

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic report_mismatch(input string test, input string where,
                                 input logic [31:0] expected, input logic [31:0] actual);
    $display("Error: %s %s expected 0x%0h actual 0x%0h", test, where, expected, actual);
    abort_run();
  endtask

  task automatic wait_for_position(input int pos);
    while (edge_cnt - 1 < pos)
    begin
      @(posedge clk_25mhz);
      #DRIVE_NS;
    end
  endtask

  // one apb transfer, setup then access until pready
  task automatic bus_access(input logic write, input logic [4:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = write ? wdata : 32'd0;
    @(posedge clk_25mhz);
    #DRIVE_NS;
    apb_req.penable = 1'b1;
    @(negedge clk_25mhz);
    while (!apb_rsp.pready)
    begin
      @(negedge clk_25mhz);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk_25mhz);
    #DRIVE_NS;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  // symbols are stable at the falling edge
  always @(negedge clk_25mhz)
  begin : compare_symbols
    int          n;
    int          x;
    int          y;
    int          frame;
    logic        hs_n;
    logic        vs_n;
    logic [15:0] exp_px;
    logic [7:0]  exp_r;
    logic [7:0]  exp_g;
    logic [7:0]  exp_b;
    logic [9:0]  exp_ctrl;
    string       test;
    string       where;
    if (arst_n && edge_cnt > PIPE_LAG)
    begin
      n     = edge_cnt - PIPE_LAG - 1;
      x     = n % LINE_PX;
      y     = (n / LINE_PX) % FRAME_LINES;
      frame = n / FRAME_PX;
      where = $sformatf("frame %0d x=%0d y=%0d", frame, x, y);
      if (x >= H_VISIBLE || y >= V_VISIBLE)
      begin
        hs_n     = !(x >= HS_FIRST && x <= HS_LAST);
        vs_n     = !(y >= VS_FIRST && y <= VS_LAST);
        exp_ctrl = CTRL_SYM[{vs_n, hs_n}];
        test     = (frame == 1) ? "sync_placement" : "blank_control";
        assert (tmds.blue == exp_ctrl)
        else report_mismatch(test, {where, " blue"}, 32'(exp_ctrl), 32'(tmds.blue));
        assert (tmds.green == CTRL_SYM[0])
        else report_mismatch(test, {where, " green"}, 32'(CTRL_SYM[0]), 32'(tmds.green));
        assert (tmds.red == CTRL_SYM[0])
        else report_mismatch(test, {where, " red"}, 32'(CTRL_SYM[0]), 32'(tmds.red));
      end
      else
      begin
        exp_px = expected_pixel(x, y, shown_buffer(frame));
        exp_r  = {exp_px[15:11], exp_px[15:13]};
        exp_g  = {exp_px[10:5], exp_px[10:9]};
        exp_b  = {exp_px[4:0], exp_px[4:2]};
        if (frame == 0)
        begin
          test = "reset_contents";
        end
        else if (frame == 1)
        begin
          test = "frame_pixels";
        end
        else
        begin
          test = "word0_update";
        end
        assert (decode_tmds(tmds.red) == exp_r)
        else report_mismatch(test, {where, " red"}, 32'(exp_r), 32'(decode_tmds(tmds.red)));
        assert (decode_tmds(tmds.green) == exp_g)
        else report_mismatch(test, {where, " green"}, 32'(exp_g), 32'(decode_tmds(tmds.green)));
        assert (decode_tmds(tmds.blue) == exp_b)
        else report_mismatch(test, {where, " blue"}, 32'(exp_b), 32'(decode_tmds(tmds.blue)));
      end
    end
  end

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk_25mhz);
      cycles = cycles + 1;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    abort_run();
  end

  initial
  begin : stimulus
    logic [31:0] rd;
    logic        err;
    clk_25mhz  = 1'b0;
    arst_n     = 1'b0;
    apb_req    = '0;
    lcg_state  = 32'd87;
    new_word0  = '0;
    for (int i = 0; i < 8; i++)
    begin
      wr_words[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk_25mhz);
    #DRIVE_NS;
    arst_n = 1'b1;

    // frame 0 text rows show the reset contents, so load below them
    wait_for_position(TEXT_LINES * LINE_PX);
    for (int i = 0; i < 8; i++)
    begin
      lcg_state   = next_random(lcg_state);
      wr_words[i] = lcg_state;
      bus_access(1'b1, 5'(4 * i), wr_words[i], rd, err);
      assert (!err)
      else report_mismatch("buffer_write", $sformatf("word %0d pslverr", i), 32'd0, 32'(err));
    end
    for (int i = 0; i < 8; i++)
    begin
      bus_access(1'b0, 5'(4 * i), 32'd0, rd, err);
      assert (rd == wr_words[i])
      else report_mismatch("readback", $sformatf("word %0d", i), wr_words[i], rd);
      assert (!err)
      else report_mismatch("readback", $sformatf("word %0d pslverr", i), 32'd0, 32'(err));
    end

    // byte offset 2 into word 3
    bus_access(1'b1, 5'd14, ~wr_words[3], rd, err);
    assert (err)
    else report_mismatch("misaligned_write", "pslverr", 32'd1, 32'(err));
    bus_access(1'b0, 5'd12, 32'd0, rd, err);
    assert (rd == wr_words[3])
    else report_mismatch("misaligned_write", "word 3 after", wr_words[3], rd);

    // vertical blanking of frame 1
    wait_for_position(FRAME_PX + V_VISIBLE * LINE_PX);
    lcg_state = next_random(lcg_state);
    new_word0 = lcg_state;
    bus_access(1'b1, 5'd0, new_word0, rd, err);
    assert (!err)
    else report_mismatch("word0_update", "write pslverr", 32'd0, 32'(err));
    bus_access(1'b0, 5'd0, 32'd0, rd, err);
    assert (rd == new_word0)
    else report_mismatch("word0_update", "readback", new_word0, rd);

    wait_for_position(END_POS);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/hex_dvi_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module hex_dvi_properties (
  input wire logic                    clk_25mhz,
  input wire logic                    arst_n,
  input wire hex_video_pkg::apb_rsp_t apb_rsp,
  input wire hex_video_pkg::beam_t    beam,
  input wire hex_video_pkg::pixel_t   pixel,
  input wire hex_video_pkg::tmds_t    tmds
);

  localparam logic [9:0] HS_START = hex_video_pkg::H_ACTIVE + hex_video_pkg::H_FRONT;
  localparam logic [9:0] HS_END   = HS_START + hex_video_pkg::H_SYNC;
  localparam logic [9:0] VS_START = hex_video_pkg::V_ACTIVE + hex_video_pkg::V_FRONT;
  localparam logic [9:0] VS_END   = VS_START + hex_video_pkg::V_SYNC;

  logic live;      // beam holds a real position from here on
  logic blank_q;   // encoder input one cycle back

  always_ff @(posedge clk_25mhz or negedge arst_n)
  begin
    if (!arst_n)
    begin
      live    <= 1'b0;
      blank_q <= 1'b1;
    end
    else
    begin
      live    <= 1'b1;
      blank_q <= pixel.blank;
    end
  end

  function automatic logic is_ctrl(input logic [9:0] sym);
    return sym == hex_video_pkg::TMDS_CTRL[0] || sym == hex_video_pkg::TMDS_CTRL[1] ||
           sym == hex_video_pkg::TMDS_CTRL[2] || sym == hex_video_pkg::TMDS_CTRL[3];
  endfunction

  pready_high: assert property (@(posedge clk_25mhz) disable iff (!arst_n) apb_rsp.pready)
    else $error("pready went low");

  beam_blank: assert property (@(posedge clk_25mhz) disable iff (!arst_n)
    live |-> beam.blank == (beam.x >= hex_video_pkg::H_ACTIVE ||
                            beam.y >= hex_video_pkg::V_ACTIVE))
    else $error("blank does not match the beam position");

  beam_syncs: assert property (@(posedge clk_25mhz) disable iff (!arst_n)
    live |-> (beam.hsync_n == !(beam.x >= HS_START && beam.x < HS_END)) &&
             (beam.vsync_n == !(beam.y >= VS_START && beam.y < VS_END)))
    else $error("sync does not match the beam position");

  // reset leaves every channel on the sync inactive symbol
  ctrl_in_blank: assert property (@(posedge clk_25mhz) disable iff (!arst_n)
    blank_q |-> is_ctrl(tmds.blue) && is_ctrl(tmds.green) && is_ctrl(tmds.red))
    else $error("data symbol during blanking");

endmodule

bind hex_dvi_top hex_dvi_properties u_props (
  .clk_25mhz (clk_25mhz),
  .arst_n    (arst_n),
  .apb_rsp   (apb_rsp),
  .beam      (beam),
  .pixel     (pixel),
  .tmds      (tmds)
);

`default_nettype wire

// ==== src/hex_dvi_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hex_dvi_top #(
  parameter int          CELL_SCALE = 2,
  parameter logic [15:0] FG_COLOR   = 16'hFFFF   // white
) (
  input  wire logic                    clk_25mhz,
  input  wire logic                    arst_n,
  input  wire hex_video_pkg::apb_req_t apb_req,
  output hex_video_pkg::apb_rsp_t      apb_rsp,
  output hex_video_pkg::tmds_t         tmds
);

  hex_video_pkg::beam_t                  beam;
  hex_video_pkg::pixel_t                 pixel;
  logic [hex_video_pkg::DISPLAY_BITS-1:0] display;
  logic [7:0]                            blue_8;
  logic [7:0]                            green_8;
  logic [7:0]                            red_8;
  logic                                  de;

  beam_timing u_timing (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .beam      (beam)
  );

  hex_display_regs u_regs (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .display   (display)
  );

  hex_glyph_renderer #(
    .CELL_SCALE (CELL_SCALE),
    .FG_COLOR   (FG_COLOR)
  ) u_render (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .beam      (beam),
    .display   (display),
    .pixel     (pixel)
  );

  // rgb565 widened to 8 bits per channel by msb replication
  assign blue_8  = {pixel.color.b, pixel.color.b[4:2]};
  assign green_8 = {pixel.color.g, pixel.color.g[5:4]};
  assign red_8   = {pixel.color.r, pixel.color.r[4:2]};
  assign de      = ~pixel.blank;

  tmds_encoder u_enc_blue (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .data      (blue_8),
    .c0        (pixel.hsync_n),   // syncs ride on blue
    .c1        (pixel.vsync_n),
    .de        (de),
    .symbol    (tmds.blue)
  );

  tmds_encoder u_enc_green (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .data      (green_8),
    .c0        (1'b0),
    .c1        (1'b0),
    .de        (de),
    .symbol    (tmds.green)
  );

  tmds_encoder u_enc_red (
    .clk_25mhz (clk_25mhz),
    .arst_n    (arst_n),
    .data      (red_8),
    .c0        (1'b0),
    .c1        (1'b0),
    .de        (de),
    .symbol    (tmds.red)
  );

endmodule

`default_nettype wire

// ==== src/tmds_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tmds_encoder (
  input  wire logic       clk_25mhz,
  input  wire logic       arst_n,
  input  wire logic [7:0] data,
  input  wire logic       c0,
  input  wire logic       c1,
  input  wire logic       de,
  output logic      [9:0] symbol
);

  logic [3:0]        n1_d;
  logic              use_xnor;
  logic [8:0]        q_m;
  logic [3:0]        n1_q;
  logic signed [5:0] bal;         // ones minus zeros in q_m[7:0]
  logic signed [5:0] disparity;
  logic signed [5:0] disp_next;
  logic [9:0]        sym_next;

  // transition minimization
  always_comb
  begin
    n1_d     = 4'($countones(data));
    use_xnor = (n1_d > 4'd4) || (n1_d == 4'd4 && !data[0]);
    q_m[0]   = data[0];
    for (int i = 1; i < 8; i++)
    begin
      q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
    end
    q_m[8] = ~use_xnor;
    n1_q   = 4'($countones(q_m[7:0]));
    bal    = $signed({1'b0, n1_q, 1'b0}) - 6'sd8;   // 2*n1 - 8
  end

  // dc balance
  always_comb
  begin
    if (disparity == 6'sd0 || bal == 6'sd0)
    begin
      sym_next  = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
      disp_next = q_m[8] ? disparity + bal : disparity - bal;
    end
    else if ((disparity > 6'sd0 && bal > 6'sd0) || (disparity < 6'sd0 && bal < 6'sd0))
    begin
      // invert to pull the running count back toward zero
      sym_next  = {1'b1, q_m[8], ~q_m[7:0]};
      disp_next = disparity + (q_m[8] ? 6'sd2 : 6'sd0) - bal;
    end
    else
    begin
      sym_next  = {1'b0, q_m[8], q_m[7:0]};
      disp_next = disparity - (q_m[8] ? 6'sd0 : 6'sd2) + bal;
    end
  end

  always_ff @(posedge clk_25mhz or negedge arst_n)
  begin
    if (!arst_n)
    begin
      symbol    <= hex_video_pkg::TMDS_CTRL[3];   // syncs inactive
      disparity <= '0;
    end
    else if (!de)
    begin
      symbol    <= hex_video_pkg::TMDS_CTRL[{c1, c0}];
      disparity <= '0;   // control periods restart the balance
    end
    else
    begin
      symbol    <= sym_next;
      disparity <= disp_next;
    end
  end

endmodule

`default_nettype wire

// ==== src/hex_glyph_renderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module hex_glyph_renderer #(
  parameter int          CELL_SCALE = 2,        // 1, 2 or 4
  parameter logic [15:0] FG_COLOR   = 16'hFFFF  // rgb565
) (
  input  wire logic                                 clk_25mhz,
  input  wire logic                                 arst_n,
  input  wire hex_video_pkg::beam_t                 beam,
  input  wire logic [hex_video_pkg::DISPLAY_BITS-1:0] display,
  output hex_video_pkg::pixel_t                     pixel
);

  localparam int SCALE_LOG2 = $clog2(CELL_SCALE);
  localparam int CELL_LOG2  = SCALE_LOG2 + 3;   // 8 font pixels per cell

  // stage 1 inputs
  logic [9:0] col;
  logic [9:0] text_row;
  logic [5:0] nib_idx;
  logic       in_text_next;

  // stage 1 registers
  hex_video_pkg::beam_t s1_beam;
  logic                 s1_in_text;
  logic [3:0]           s1_nibble;
  logic [2:0]           s1_font_row;
  logic [2:0]           s1_font_col;

  // stage 2 lookup
  logic [7:0] glyph_row;
  logic       font_bit;

  always_comb
  begin
    col      = beam.x >> CELL_LOG2;
    text_row = beam.y >> CELL_LOG2;
    // only 32 digit columns per row, the rest of the line stays dark
    in_text_next = !beam.blank && (text_row < 10'd2) &&
                   (col < 10'(hex_video_pkg::DIGITS_PER_ROW));
    // 31 - col is the bitwise inverse for a 5-bit column
    nib_idx = {text_row[0], ~col[4:0]};
  end

  always_ff @(posedge clk_25mhz or negedge arst_n)
  begin
    if (!arst_n)
    begin
      s1_beam.x       <= '0;
      s1_beam.y       <= '0;
      s1_beam.hsync_n <= 1'b1;
      s1_beam.vsync_n <= 1'b1;
      s1_beam.blank   <= 1'b1;
      s1_in_text      <= 1'b0;
    end
    else
    begin
      s1_beam    <= beam;
      s1_in_text <= in_text_next;
    end
  end

  // payload, qualified by s1_in_text
  always_ff @(posedge clk_25mhz)
  begin
    s1_nibble   <= display[{nib_idx, 2'b00} +: 4];
    s1_font_row <= beam.y[SCALE_LOG2 +: 3];
    s1_font_col <= beam.x[SCALE_LOG2 +: 3];
  end

  always_comb
  begin
    glyph_row = hex_video_pkg::HEX_FONT[s1_nibble][s1_font_row];
    font_bit  = glyph_row[~s1_font_col];   // bit 7 is leftmost
  end

  always_ff @(posedge clk_25mhz or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pixel.color   <= '0;
      pixel.hsync_n <= 1'b1;
      pixel.vsync_n <= 1'b1;
      pixel.blank   <= 1'b1;
    end
    else
    begin
      if (s1_in_text && font_bit)
      begin
        pixel.color <= hex_video_pkg::rgb565_t'(FG_COLOR);
      end
      else
      begin
        pixel.color <= '0;   // background and blanking
      end
      pixel.hsync_n <= s1_beam.hsync_n;
      pixel.vsync_n <= s1_beam.vsync_n;
      pixel.blank   <= s1_beam.blank;
    end
  end

endmodule

`default_nettype wire

// ==== src/hex_display_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module hex_display_regs (
  input  wire logic                                   clk_25mhz,
  input  wire logic                                   arst_n,
  input  wire hex_video_pkg::apb_req_t                apb_req,
  output hex_video_pkg::apb_rsp_t                     apb_rsp,
  output logic [hex_video_pkg::DISPLAY_BITS-1:0]      display
);

  logic [31:0] words [hex_video_pkg::BUF_WORDS];
  logic [2:0]  word_sel;
  logic        aligned;
  logic        access;
  logic        wr_en;

  assign word_sel = apb_req.paddr[4:2];
  assign aligned  = (apb_req.paddr[1:0] == 2'b00);
  assign access   = apb_req.psel & apb_req.penable;
  assign wr_en    = access & apb_req.pwrite & aligned; // misaligned writes dropped

  always_ff @(posedge clk_25mhz or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < hex_video_pkg::BUF_WORDS; i++)
      begin
        words[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      words[word_sel] <= apb_req.pwdata;
    end
  end

  // zero wait states
  always_comb
  begin
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = access & ~aligned;
    apb_rsp.prdata  = '0;
    if (apb_req.psel && !apb_req.pwrite && aligned)
    begin
      apb_rsp.prdata = words[word_sel];
    end
  end

  // word 0 sits in the low bits
  always_comb
  begin
    for (int i = 0; i < hex_video_pkg::BUF_WORDS; i++)
    begin
      display[32*i +: 32] = words[i];
    end
  end

endmodule

`default_nettype wire

// ==== src/beam_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module beam_timing (
  input  wire logic            clk_25mhz,
  input  wire logic            arst_n,
  output hex_video_pkg::beam_t beam
);

  localparam logic [9:0] HS_START = hex_video_pkg::H_ACTIVE + hex_video_pkg::H_FRONT;
  localparam logic [9:0] HS_END   = HS_START + hex_video_pkg::H_SYNC;
  localparam logic [9:0] VS_START = hex_video_pkg::V_ACTIVE + hex_video_pkg::V_FRONT;
  localparam logic [9:0] VS_END   = VS_START + hex_video_pkg::V_SYNC;

  logic [9:0] h_cnt;
  logic [9:0] v_cnt;
  logic       h_last;
  logic       v_last;
  logic       hsync_n_next;
  logic       vsync_n_next;
  logic       blank_next;

  assign h_last = (h_cnt == hex_video_pkg::H_TOTAL - 10'd1);
  assign v_last = (v_cnt == hex_video_pkg::V_TOTAL - 10'd1);

  // free running raster position
  always_ff @(posedge clk_25mhz or negedge arst_n)
  begin
    if (!arst_n)
    begin
      h_cnt <= '0;
      v_cnt <= '0;
    end
    else
    begin
      h_cnt <= h_last ? 10'd0 : h_cnt + 10'd1;
      if (h_last)
      begin
        v_cnt <= v_last ? 10'd0 : v_cnt + 10'd1;
      end
    end
  end

  // decoded from the same count that is registered below
  always_comb
  begin
    hsync_n_next = !(h_cnt >= HS_START && h_cnt < HS_END);
    vsync_n_next = !(v_cnt >= VS_START && v_cnt < VS_END);
    blank_next   = (h_cnt >= hex_video_pkg::H_ACTIVE) || (v_cnt >= hex_video_pkg::V_ACTIVE);
  end

  always_ff @(posedge clk_25mhz or negedge arst_n)
  begin
    if (!arst_n)
    begin
      beam.x       <= '0;
      beam.y       <= '0;
      beam.hsync_n <= 1'b1;
      beam.vsync_n <= 1'b1;
      beam.blank   <= 1'b1;   // dark until the first count is out
    end
    else
    begin
      beam.x       <= h_cnt;
      beam.y       <= v_cnt;
      beam.hsync_n <= hsync_n_next;
      beam.vsync_n <= vsync_n_next;
      beam.blank   <= blank_next;
    end
  end

endmodule

`default_nettype wire

// ==== src/hex_video_pkg.sv ====
`default_nettype none

package hex_video_pkg;

  // 640x480 at 60 Hz, syncs active low
  localparam logic [9:0] H_ACTIVE = 10'd640;
  localparam logic [9:0] H_FRONT  = 10'd16;
  localparam logic [9:0] H_SYNC   = 10'd96;
  localparam logic [9:0] H_BACK   = 10'd48;
  localparam logic [9:0] H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam logic [9:0] V_ACTIVE = 10'd480;
  localparam logic [9:0] V_FRONT  = 10'd10;
  localparam logic [9:0] V_SYNC   = 10'd2;
  localparam logic [9:0] V_BACK   = 10'd33;
  localparam logic [9:0] V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  localparam int BUF_WORDS      = 8;
  localparam int DISPLAY_BITS   = BUF_WORDS * 32;
  localparam int DIGITS_PER_ROW = 32;

  // glyph rows top to bottom, bit 7 is the left column
  localparam logic [7:0] HEX_FONT [16][8] = '{
    '{8'h3C, 8'h66, 8'h6E, 8'h76, 8'h66, 8'h66, 8'h3C, 8'h00}, // 0
    '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00}, // 1
    '{8'h3C, 8'h66, 8'h06, 8'h0C, 8'h30, 8'h60, 8'h7E, 8'h00}, // 2
    '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00}, // 3
    '{8'h0C, 8'h1C, 8'h3C, 8'h6C, 8'h7E, 8'h0C, 8'h0C, 8'h00}, // 4
    '{8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00}, // 5
    '{8'h3C, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h66, 8'h3C, 8'h00}, // 6
    '{8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00}, // 7
    '{8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00}, // 8
    '{8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h0C, 8'h38, 8'h00}, // 9
    '{8'h18, 8'h3C, 8'h66, 8'h66, 8'h7E, 8'h66, 8'h66, 8'h00}, // a
    '{8'h7C, 8'h66, 8'h66, 8'h7C, 8'h66, 8'h66, 8'h7C, 8'h00}, // b
    '{8'h3C, 8'h66, 8'h60, 8'h60, 8'h60, 8'h66, 8'h3C, 8'h00}, // c
    '{8'h78, 8'h6C, 8'h66, 8'h66, 8'h66, 8'h6C, 8'h78, 8'h00}, // d
    '{8'h7E, 8'h60, 8'h60, 8'h7C, 8'h60, 8'h60, 8'h7E, 8'h00}, // e
    '{8'h7E, 8'h60, 8'h60, 8'h7C, 8'h60, 8'h60, 8'h60, 8'h00}  // f
  };

  // dvi control symbols, indexed by {c1, c0}
  localparam logic [9:0] TMDS_CTRL [4] = '{
    10'b1101010100, 10'b0010101011, 10'b0101010100, 10'b1010101011
  };

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;   // byte address
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic [9:0] x;
    logic [9:0] y;
    logic       hsync_n;
    logic       vsync_n;
    logic       blank;
  } beam_t;

  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  typedef struct packed {
    rgb565_t color;
    logic    hsync_n;
    logic    vsync_n;
    logic    blank;
  } pixel_t;

  typedef struct packed {
    logic [9:0] blue;
    logic [9:0] green;
    logic [9:0] red;
  } tmds_t;

endpackage

`default_nettype wire
